//--- logic/board_params.svh
`ifndef BOARD_PARAMS_SVH
`define BOARD_PARAMS_SVH

// Horizontal timing of the 640x480 frame in clock cycles.
`define H_ACTIVE      640
`define H_SYNC_START  656
`define H_SYNC_END    752
`define H_TOTAL       800

// Vertical values in lines.
`define V_ACTIVE      480
`define V_SYNC_START  490
`define V_SYNC_END    492
`define V_TOTAL       525

// Cells are 8x8 pixels.
`define CELL_SHIFT    3

// One colour word per cell.
`define FB_COLS       80
`define FB_ROWS       60
`define FB_DEPTH      4800

`endif

//--- logic/video_pkg.sv
package video_pkg;

    // Horizontal or vertical pixel position.
    typedef logic [9:0] pixel_coord_t;

    // Cell index, row * 80 + column.
    typedef logic [12:0] cell_addr_t;

    // RGB444, red in the top nibble.
    typedef logic [11:0] colour_t;

endpackage

//--- logic/input_pkg.sv
package input_pkg;

    // One byte from the keyboard.
    typedef logic [7:0] scan_code_t;

    // ALU operand and result width.
    typedef logic [3:0] nibble_t;

    // ALU function select.
    typedef enum logic [2:0] {
        ADD,
        SUB,
        NOT_A,
        AND,
        OR,
        XOR,
        LESS_THAN,
        EQUAL
    } alu_op_e;

endpackage

//--- logic/ps2_receiver.sv
`timescale 1ns/100ps

module ps2_receiver (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  ps2_clk,
    input  logic                  ps2_data,
    output input_pkg::scan_code_t code,
    output logic                  code_valid
);

    typedef enum logic [1:0] {IDLE, DATA, PARITY, STOP} rx_state_e;

    rx_state_e             state;
    logic [2:0]            clk_sync;
    logic [1:0]            data_sync;
    logic [2:0]            bit_cnt;
    logic                  fall;
    logic                  data_bit;
    logic                  start_bit;
    logic                  parity_bit;
    input_pkg::scan_code_t shift;

    // Data goes through the same two flops as the clock so both stay aligned.
    assign fall     = clk_sync[2] & ~clk_sync[1];
    assign data_bit = data_sync[1];

    always_ff @(posedge clk) begin
        if (reset) begin
            clk_sync   <= '1;
            data_sync  <= '1;
            state      <= IDLE;
            bit_cnt    <= '0;
            code_valid <= 1'b0;
        end else begin
            clk_sync   <= {clk_sync[1:0], ps2_clk};
            data_sync  <= {data_sync[0], ps2_data};
            code_valid <= 1'b0;
            if (fall) begin
                case (state)
                    IDLE: begin
                        bit_cnt <= '0;
                        state   <= DATA;
                    end
                    DATA: begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= PARITY;
                        end
                    end
                    PARITY: state <= STOP;
                    STOP: begin
                        // Odd parity over data and parity bit.
                        code_valid <= !start_bit && data_bit && (^{shift, parity_bit});
                        state      <= IDLE;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fall) begin
            case (state)
                IDLE:   start_bit  <= data_bit;
                DATA:   shift      <= {data_bit, shift[7:1]};
                PARITY: parity_bit <= data_bit;
                STOP:   code       <= shift;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (reset) code_valid |=> !code_valid);

endmodule

//--- logic/alu_4bit.sv
`timescale 1ns/100ps

module alu_4bit (
    input  input_pkg::alu_op_e alu_op,
    input  input_pkg::nibble_t alu_a,
    input  input_pkg::nibble_t alu_b,
    output input_pkg::nibble_t alu_res,
    output logic               alu_zero,
    output logic               alu_carry,
    output logic               alu_overflow
);

    logic [4:0] sum_ext;
    logic [4:0] diff_ext;

    // Bit 4 is the carry out, or the borrow for a subtraction.
    assign sum_ext  = {1'b0, alu_a} + {1'b0, alu_b};
    assign diff_ext = {1'b0, alu_a} - {1'b0, alu_b};

    always_comb begin
        alu_res      = '0;
        alu_carry    = 1'b0;
        alu_overflow = 1'b0;
        case (alu_op)
            input_pkg::ADD: begin
                alu_res      = sum_ext[3:0];
                alu_carry    = sum_ext[4];
                alu_overflow = (alu_a[3] == alu_b[3]) && (sum_ext[3] != alu_a[3]);
            end
            input_pkg::SUB: begin
                alu_res      = diff_ext[3:0];
                alu_carry    = diff_ext[4];
                alu_overflow = (alu_a[3] != alu_b[3]) && (diff_ext[3] != alu_a[3]);
            end
            input_pkg::NOT_A:     alu_res = ~alu_a;
            input_pkg::AND:       alu_res = alu_a & alu_b;
            input_pkg::OR:        alu_res = alu_a | alu_b;
            input_pkg::XOR:       alu_res = alu_a ^ alu_b;
            input_pkg::LESS_THAN: alu_res = {3'b000, $signed(alu_a) < $signed(alu_b)};
            input_pkg::EQUAL:     alu_res = {3'b000, alu_a == alu_b};
        endcase
    end

    assign alu_zero = (alu_res == 4'd0);

endmodule

//--- logic/seg_display.sv
`timescale 1ns/100ps

module seg_display (
    input  logic                  clk,
    input  logic                  reset,
    input  input_pkg::scan_code_t code,
    input  logic                  code_valid,
    output logic [7:0]            seg0,
    output logic [7:0]            seg1,
    output logic [7:0]            seg2,
    output logic [7:0]            seg3,
    output logic [7:0]            seg4,
    output logic [7:0]            seg5,
    output logic [7:0]            seg6,
    output logic [7:0]            seg7
);

    // Entry 0 is the newest code.
    input_pkg::scan_code_t history [4];

    // Segments a..g on bits 0..6, active low, decimal point off.
    function automatic logic [7:0] hex_to_seg(input logic [3:0] value);
        case (value)
            4'h0: return 8'hC0;
            4'h1: return 8'hF9;
            4'h2: return 8'hA4;
            4'h3: return 8'hB0;
            4'h4: return 8'h99;
            4'h5: return 8'h92;
            4'h6: return 8'h82;
            4'h7: return 8'hF8;
            4'h8: return 8'h80;
            4'h9: return 8'h90;
            4'hA: return 8'h88;
            4'hB: return 8'h83;
            4'hC: return 8'hC6;
            4'hD: return 8'hA1;
            4'hE: return 8'h86;
            default: return 8'h8E;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            history <= '{default: '0};
        end else if (code_valid) begin
            history <= '{code, history[0], history[1], history[2]};
        end
    end

    assign seg0 = hex_to_seg(history[0][3:0]);
    assign seg1 = hex_to_seg(history[0][7:4]);
    assign seg2 = hex_to_seg(history[1][3:0]);
    assign seg3 = hex_to_seg(history[1][7:4]);
    assign seg4 = hex_to_seg(history[2][3:0]);
    assign seg5 = hex_to_seg(history[2][7:4]);
    assign seg6 = hex_to_seg(history[3][3:0]);
    assign seg7 = hex_to_seg(history[3][7:4]);

endmodule

//--- logic/vga_timing.sv
`timescale 1ns/100ps
`include "board_params.svh"

module vga_timing (
    input  logic                 clk,
    input  logic                 reset,
    output logic                 fetch_req,
    output video_pkg::cell_addr_t fetch_addr,
    input  video_pkg::colour_t   fetch_data,
    output logic                 hsync,
    output logic                 vsync,
    output logic                 blank_n,
    output logic [7:0]           vga_r,
    output logic [7:0]           vga_g,
    output logic [7:0]           vga_b
);

    video_pkg::pixel_coord_t h_cnt;
    video_pkg::pixel_coord_t v_cnt;
    video_pkg::pixel_coord_t h_next;
    video_pkg::pixel_coord_t v_next;
    video_pkg::pixel_coord_t line_next;
    logic                    at_line_end;
    logic                    fetch_done;
    video_pkg::colour_t      cell_colour;

    assign at_line_end = (h_cnt == `H_TOTAL - 1);
    assign h_next      = at_line_end ? '0 : h_cnt + 1'b1;
    assign v_next      = (v_cnt == `V_TOTAL - 1) ? '0 : v_cnt + 1'b1;
    assign line_next   = at_line_end ? v_next : v_cnt;

    // Fetch one pixel ahead of each active cell; the colour arrives with its first pixel.
    assign fetch_req  = (line_next < `V_ACTIVE) && (h_next < `H_ACTIVE) &&
                        (h_next[`CELL_SHIFT-1:0] == '0);
    assign fetch_addr = video_pkg::cell_addr_t'(line_next >> `CELL_SHIFT) *
                        video_pkg::cell_addr_t'(`FB_COLS) +
                        video_pkg::cell_addr_t'(h_next >> `CELL_SHIFT);

    always_ff @(posedge clk) begin
        if (reset) begin
            h_cnt       <= '0;
            v_cnt       <= '0;
            hsync       <= 1'b1;
            vsync       <= 1'b1;
            blank_n     <= 1'b0;
            fetch_done  <= 1'b0;
            cell_colour <= '0;
        end else begin
            h_cnt <= h_next;
            if (at_line_end) begin
                v_cnt <= v_next;
            end
            // Outputs lag the counters by one cycle.
            hsync      <= !((h_cnt >= `H_SYNC_START) && (h_cnt < `H_SYNC_END));
            vsync      <= !((v_cnt >= `V_SYNC_START) && (v_cnt < `V_SYNC_END));
            blank_n    <= (h_cnt < `H_ACTIVE) && (v_cnt < `V_ACTIVE);
            fetch_done <= fetch_req;
            if (fetch_done) begin
                cell_colour <= fetch_data;
            end
        end
    end

    assign vga_r = blank_n ? {2{cell_colour[11:8]}} : 8'd0;
    assign vga_g = blank_n ? {2{cell_colour[7:4]}}  : 8'd0;
    assign vga_b = blank_n ? {2{cell_colour[3:0]}}  : 8'd0;

endmodule

//--- logic/cell_painter.sv
`timescale 1ns/100ps
`include "board_params.svh"

module cell_painter (
    input  logic                  clk,
    input  logic                  reset,
    input  input_pkg::scan_code_t code,
    input  logic                  code_valid,
    input  logic [7:0]            sw,
    output logic                  wr_req,
    output video_pkg::cell_addr_t wr_addr,
    output video_pkg::colour_t    wr_colour,
    input  logic                  wr_ack
);

    localparam input_pkg::scan_code_t KEY_BREAK = 8'hF0;
    localparam input_pkg::scan_code_t KEY_UP    = 8'h1D;
    localparam input_pkg::scan_code_t KEY_DOWN  = 8'h1B;
    localparam input_pkg::scan_code_t KEY_LEFT  = 8'h1C;
    localparam input_pkg::scan_code_t KEY_RIGHT = 8'h23;

    logic [6:0] cursor_col;
    logic [5:0] cursor_row;
    logic       break_next;

    // The cursor is frozen while a write waits, so the address holds.
    assign wr_addr = video_pkg::cell_addr_t'(cursor_row) * video_pkg::cell_addr_t'(`FB_COLS) +
                     video_pkg::cell_addr_t'(cursor_col);

    always_ff @(posedge clk) begin
        if (reset) begin
            cursor_col <= '0;
            cursor_row <= '0;
            break_next <= 1'b0;
            wr_req     <= 1'b0;
        end else if (wr_req) begin
            if (wr_ack) begin
                wr_req <= 1'b0;
            end
        end else if (code_valid) begin
            if (code == KEY_BREAK) begin
                break_next <= 1'b1;
            end else if (break_next) begin
                break_next <= 1'b0;
            end else begin
                case (code)
                    KEY_UP:    cursor_row <= (cursor_row == '0) ? 6'(`FB_ROWS - 1)
                                                                : cursor_row - 1'b1;
                    KEY_DOWN:  cursor_row <= (cursor_row == 6'(`FB_ROWS - 1)) ? '0
                                                                : cursor_row + 1'b1;
                    KEY_LEFT:  cursor_col <= (cursor_col == '0) ? 7'(`FB_COLS - 1)
                                                                : cursor_col - 1'b1;
                    KEY_RIGHT: cursor_col <= (cursor_col == 7'(`FB_COLS - 1)) ? '0
                                                                : cursor_col + 1'b1;
                    default:   wr_req <= 1'b1;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (code_valid && !wr_req) begin
            wr_colour <= {sw, code[3:0]};
        end
    end

endmodule

//--- logic/vmem_arbiter.sv
`timescale 1ns/100ps
`include "board_params.svh"

module vmem_arbiter (
    input  logic                  clk,
    input  logic                  fetch_req,
    input  video_pkg::cell_addr_t fetch_addr,
    output video_pkg::colour_t    fetch_data,
    input  logic                  wr_req,
    input  video_pkg::cell_addr_t wr_addr,
    input  video_pkg::colour_t    wr_colour,
    output logic                  wr_ack
);

    video_pkg::colour_t mem [0:`FB_DEPTH-1];

    // Screen starts black.
    initial begin
        for (int i = 0; i < `FB_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // Display reads always win; a write slips into any cycle without a fetch.
    assign wr_ack = wr_req && !fetch_req;

    always_ff @(posedge clk) begin
        if (fetch_req) begin
            fetch_data <= mem[fetch_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ack) begin
            mem[wr_addr] <= wr_colour;
        end
    end

    // The single port never sees a read and a write in the same cycle.
    assert property (@(posedge clk) wr_ack |-> (wr_req && !fetch_req));

    // The painter keeps its request steady until it is served.
    assert property (@(posedge clk)
        (wr_req && !wr_ack) |=> (wr_req && $stable(wr_addr) && $stable(wr_colour)));

endmodule

//--- logic/lab_board.sv
`timescale 1ns/100ps

module lab_board (
    input  logic               clk,
    input  logic               reset,
    input  logic [7:0]         sw,
    input  logic               ps2_clk,
    input  logic               ps2_data,
    input  input_pkg::alu_op_e alu_op,
    input  input_pkg::nibble_t alu_a,
    input  input_pkg::nibble_t alu_b,
    output logic               VGA_CLK,
    output logic               VGA_HSYNC,
    output logic               VGA_VSYNC,
    output logic               VGA_BLANK_N,
    output logic [7:0]         VGA_R,
    output logic [7:0]         VGA_G,
    output logic [7:0]         VGA_B,
    output logic [7:0]         seg0,
    output logic [7:0]         seg1,
    output logic [7:0]         seg2,
    output logic [7:0]         seg3,
    output logic [7:0]         seg4,
    output logic [7:0]         seg5,
    output logic [7:0]         seg6,
    output logic [7:0]         seg7,
    output input_pkg::nibble_t alu_res,
    output logic               alu_zero,
    output logic               alu_carry,
    output logic               alu_overflow
);

    input_pkg::scan_code_t code;
    logic                  code_valid;
    logic                  fetch_req;
    video_pkg::cell_addr_t fetch_addr;
    video_pkg::colour_t    fetch_data;
    logic                  wr_req;
    video_pkg::cell_addr_t wr_addr;
    video_pkg::colour_t    wr_colour;
    logic                  wr_ack;

    assign VGA_CLK = clk;

    ps2_receiver u_ps2 (
        .clk        (clk),
        .reset      (reset),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .code       (code),
        .code_valid (code_valid)
    );

    alu_4bit u_alu (
        .alu_op       (alu_op),
        .alu_a        (alu_a),
        .alu_b        (alu_b),
        .alu_res      (alu_res),
        .alu_zero     (alu_zero),
        .alu_carry    (alu_carry),
        .alu_overflow (alu_overflow)
    );

    seg_display u_seg (
        .clk        (clk),
        .reset      (reset),
        .code       (code),
        .code_valid (code_valid),
        .seg0       (seg0),
        .seg1       (seg1),
        .seg2       (seg2),
        .seg3       (seg3),
        .seg4       (seg4),
        .seg5       (seg5),
        .seg6       (seg6),
        .seg7       (seg7)
    );

    vga_timing u_vga (
        .clk        (clk),
        .reset      (reset),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data),
        .hsync      (VGA_HSYNC),
        .vsync      (VGA_VSYNC),
        .blank_n    (VGA_BLANK_N),
        .vga_r      (VGA_R),
        .vga_g      (VGA_G),
        .vga_b      (VGA_B)
    );

    cell_painter u_painter (
        .clk        (clk),
        .reset      (reset),
        .code       (code),
        .code_valid (code_valid),
        .sw         (sw),
        .wr_req     (wr_req),
        .wr_addr    (wr_addr),
        .wr_colour  (wr_colour),
        .wr_ack     (wr_ack)
    );

    vmem_arbiter u_vmem (
        .clk        (clk),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data),
        .wr_req     (wr_req),
        .wr_addr    (wr_addr),
        .wr_colour  (wr_colour),
        .wr_ack     (wr_ack)
    );

endmodule

//--- sim/clock_gen.sv
`timescale 1ns/100ps

module clock_gen (
    output logic clk,
    output logic reset
);

    // 20 ns period.
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- sim/lab_board_tb.sv
`timescale 1ns/100ps
`include "board_params.svh"

module lab_board_tb;

    // Operand pairs {a, b}. Each pair runs through all eight operations.
    localparam logic [7:0] ALU_PAIRS [8] = '{
        8'h00, 8'h71, 8'h88, 8'hF1, 8'h39, 8'h81, 8'h55, 8'hFF
    };

    // Key frames as {shown, code}. A row with shown low is sent with wrong parity.
    localparam logic [8:0] KEY_TABLE [10] = '{
        {1'b1, 8'h45},
        {1'b1, 8'h16},
        {1'b0, 8'hA7},
        {1'b1, 8'h23},
        {1'b1, 8'h23},
        {1'b1, 8'hF0},
        {1'b1, 8'h23},
        {1'b1, 8'h1B},
        {1'b0, 8'h3C},
        {1'b1, 8'h2D}
    };

    // Lit segments gfedcba of each hex digit.
    localparam logic [6:0] SEG_LIT [16] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
        7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
    };

    logic               clk;
    logic               reset;
    logic [7:0]         sw;
    logic               ps2_clk;
    logic               ps2_data;
    input_pkg::alu_op_e alu_op;
    input_pkg::nibble_t alu_a;
    input_pkg::nibble_t alu_b;
    logic               vga_clk;
    logic               vga_hsync;
    logic               vga_vsync;
    logic               vga_blank_n;
    logic [7:0]         vga_r;
    logic [7:0]         vga_g;
    logic [7:0]         vga_b;
    logic [7:0]         seg0;
    logic [7:0]         seg1;
    logic [7:0]         seg2;
    logic [7:0]         seg3;
    logic [7:0]         seg4;
    logic [7:0]         seg5;
    logic [7:0]         seg6;
    logic [7:0]         seg7;
    input_pkg::nibble_t alu_res;
    logic               alu_zero;
    logic               alu_carry;
    logic               alu_overflow;

    int          checks;
    int          errors;
    logic [7:0]  shown [4];
    int          cursor_col;
    int          cursor_row;
    logic        break_pending;
    logic [11:0] painted [int];

    clock_gen clocks (
        .clk   (clk),
        .reset (reset)
    );

    lab_board uut (
        .clk          (clk),
        .reset        (reset),
        .sw           (sw),
        .ps2_clk      (ps2_clk),
        .ps2_data     (ps2_data),
        .alu_op       (alu_op),
        .alu_a        (alu_a),
        .alu_b        (alu_b),
        .VGA_CLK      (vga_clk),
        .VGA_HSYNC    (vga_hsync),
        .VGA_VSYNC    (vga_vsync),
        .VGA_BLANK_N  (vga_blank_n),
        .VGA_R        (vga_r),
        .VGA_G        (vga_g),
        .VGA_B        (vga_b),
        .seg0         (seg0),
        .seg1         (seg1),
        .seg2         (seg2),
        .seg3         (seg3),
        .seg4         (seg4),
        .seg5         (seg5),
        .seg6         (seg6),
        .seg7         (seg7),
        .alu_res      (alu_res),
        .alu_zero     (alu_zero),
        .alu_carry    (alu_carry),
        .alu_overflow (alu_overflow)
    );

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        errors++;
        $display("error at %0t ns: %s expected %0h, got %0h", $time, name, expected, got);
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout at %0t ns while waiting for %s", $time, what);
    endtask

    // Result in bits 3:0, then zero, carry and overflow.
    function automatic logic [6:0] alu_expect(input input_pkg::alu_op_e op,
                                              input logic [3:0] a, input logic [3:0] b);
        int         ua;
        int         ub;
        int         sa;
        int         sb;
        int         value;
        logic [3:0] res;
        logic       carry;
        logic       overflow;
        ua       = {28'd0, a};
        ub       = {28'd0, b};
        sa       = a[3] ? ua - 16 : ua;
        sb       = b[3] ? ub - 16 : ub;
        res      = 4'd0;
        carry    = 1'b0;
        overflow = 1'b0;
        case (op)
            input_pkg::ADD: begin
                value    = ua + ub;
                res      = value[3:0];
                carry    = (value > 15);
                overflow = (sa + sb > 7) || (sa + sb < -8);
            end
            input_pkg::SUB: begin
                value    = ua - ub;
                res      = value[3:0];
                carry    = (ua < ub);
                overflow = (sa - sb > 7) || (sa - sb < -8);
            end
            input_pkg::NOT_A:     res = ~a;
            input_pkg::AND:       res = a & b;
            input_pkg::OR:        res = a | b;
            input_pkg::XOR:       res = a ^ b;
            input_pkg::LESS_THAN: res = (sa < sb) ? 4'd1 : 4'd0;
            input_pkg::EQUAL:     res = (a == b) ? 4'd1 : 4'd0;
        endcase
        return {overflow, carry, res == 4'd0, res};
    endfunction

    function automatic logic [7:0] seg_pattern(input logic [3:0] digit);
        return {1'b1, ~SEG_LIT[digit]};
    endfunction

    function automatic logic sync_level(input logic vertical);
        return vertical ? vga_vsync : vga_hsync;
    endfunction

    task automatic check_display();
        logic [7:0] got [8];
        logic [3:0] digit;
        got = '{seg0, seg1, seg2, seg3, seg4, seg5, seg6, seg7};
        for (int d = 0; d < 8; d++) begin
            digit = d[0] ? shown[d / 2][7:4] : shown[d / 2][3:0];
            checks++;
            if (got[d] !== seg_pattern(digit)) begin
                report_mismatch($sformatf("seg%0d", d), 32'(got[d]), 32'(seg_pattern(digit)));
            end
        end
    endtask

    // Called just after a falling clock edge, it samples both clock phases.
    task automatic check_vga_clk();
        #5;
        checks++;
        if (vga_clk !== 1'b0) begin
            report_mismatch("vga_clk", 32'(vga_clk), 32'd0);
        end
        #10;
        checks++;
        if (vga_clk !== 1'b1) begin
            report_mismatch("vga_clk", 32'(vga_clk), 32'd1);
        end
    endtask

    // Expected cursor and cell contents after a received key.
    task automatic track_painter_key(input logic [7:0] key);
        if (key == 8'hF0) begin
            break_pending = 1'b1;
        end else if (break_pending) begin
            break_pending = 1'b0;
        end else begin
            case (key)
                8'h1D:   cursor_row = (cursor_row + `FB_ROWS - 1) % `FB_ROWS;
                8'h1B:   cursor_row = (cursor_row + 1) % `FB_ROWS;
                8'h1C:   cursor_col = (cursor_col + `FB_COLS - 1) % `FB_COLS;
                8'h23:   cursor_col = (cursor_col + 1) % `FB_COLS;
                default: painted[cursor_row * `FB_COLS + cursor_col] = {sw, key[3:0]};
            endcase
        end
    endtask

    // Start, 8 data bits LSB first, parity, stop; 40 clocks per half period.
    task automatic send_ps2_frame(input logic [7:0] value, input logic parity_ok,
                                  output logic got_valid);
        logic [10:0] frame;
        logic        parity;
        parity = ~^value;
        if (!parity_ok) begin
            parity = ~parity;
        end
        frame     = {1'b1, parity, value, 1'b0};
        got_valid = 1'b0;
        for (int i = 0; i < 11; i++) begin
            @(posedge clk);
            ps2_data <= frame[i];
            repeat (40) @(posedge clk);
            ps2_clk <= 1'b0;
            for (int t = 0; t < 40; t++) begin
                @(negedge clk);
                if (uut.code_valid) begin
                    got_valid = 1'b1;
                end
            end
            @(posedge clk);
            ps2_clk <= 1'b1;
        end
    endtask

    task automatic wait_sync_fall(input logic vertical, output logic found);
        int   limit;
        logic prev;
        limit = vertical ? 2 * `V_TOTAL * `H_TOTAL : 2 * `H_TOTAL;
        found = 1'b0;
        prev  = sync_level(vertical);
        for (int t = 0; t < limit && !found; t++) begin
            @(negedge clk);
            found = prev && !sync_level(vertical);
            prev  = sync_level(vertical);
        end
    endtask

    // Cycles from one falling edge to the next, and cycles spent low.
    task automatic measure_sync(input logic vertical, output int period, output int low,
                                output logic found);
        int   limit;
        logic prev;
        limit  = vertical ? 2 * `V_TOTAL * `H_TOTAL : 2 * `H_TOTAL;
        period = 0;
        low    = 0;
        wait_sync_fall(vertical, found);
        if (found) begin
            period = 1;
            low    = 1;
            prev   = 1'b0;
            found  = 1'b0;
            for (int t = 0; t < limit; t++) begin
                @(negedge clk);
                if (prev && !sync_level(vertical)) begin
                    found = 1'b1;
                    break;
                end
                period++;
                if (!sync_level(vertical)) begin
                    low++;
                end
                prev = sync_level(vertical);
            end
        end
    endtask

    // Samples the first pixel of a cell in the next frame.
    task automatic probe_cell(input int col, input int row);
        logic        found;
        logic        prev;
        int          rises;
        int          addr;
        logic [11:0] colour;
        wait_sync_fall(1'b1, found);
        rises = 0;
        prev  = vga_blank_n;
        for (int t = 0; found && rises < row * 8 + 1 && t < `V_TOTAL * `H_TOTAL; t++) begin
            @(negedge clk);
            if (!prev && vga_blank_n) begin
                rises++;
            end
            prev = vga_blank_n;
        end
        if (!found || rises < row * 8 + 1) begin
            report_timeout($sformatf("the active line of cell (%0d, %0d)", col, row));
        end else begin
            repeat (col * 8) @(negedge clk);
            addr   = row * `FB_COLS + col;
            colour = painted.exists(addr) ? painted[addr] : 12'h000;
            checks += 4;
            if (vga_blank_n !== 1'b1) begin
                report_mismatch("vga_blank_n", 32'(vga_blank_n), 32'd1);
            end
            if (vga_r !== {2{colour[11:8]}}) begin
                report_mismatch("vga_r", 32'(vga_r), 32'({2{colour[11:8]}}));
            end
            if (vga_g !== {2{colour[7:4]}}) begin
                report_mismatch("vga_g", 32'(vga_g), 32'({2{colour[7:4]}}));
            end
            if (vga_b !== {2{colour[3:0]}}) begin
                report_mismatch("vga_b", 32'(vga_b), 32'({2{colour[3:0]}}));
            end
        end
    endtask

    initial begin
        logic [7:0]  pair;
        logic [6:0]  expected;
        logic [8:0]  key_row;
        logic        got_valid;
        logic        found;
        int          period;
        int          low;
        checks        = 0;
        errors        = 0;
        cursor_col    = 0;
        cursor_row    = 0;
        break_pending = 1'b0;
        shown         = '{default: 8'h00};
        sw            = 8'h00;
        ps2_clk       = 1'b1;
        ps2_data      = 1'b1;
        alu_op        = input_pkg::ADD;
        alu_a         = 4'd0;
        alu_b         = 4'd0;
        void'($urandom(32'h1d68_241c));

        for (int t = 0; t < 100 && reset !== 1'b0; t++) begin
            @(negedge clk);
        end
        if (reset !== 1'b0) begin
            report_timeout("reset to be released");
        end
        @(negedge clk);
        checks += 2;
        if (vga_hsync !== 1'b1) begin
            report_mismatch("vga_hsync", 32'(vga_hsync), 32'd1);
        end
        if (vga_vsync !== 1'b1) begin
            report_mismatch("vga_vsync", 32'(vga_vsync), 32'd1);
        end
        check_display();
        check_vga_clk();

        @(posedge clk);
        sw <= 8'($urandom());

        // Fixed pairs first, then 16 random pairs.
        for (int row = 0; row < 24; row++) begin
            pair = (row < 8) ? ALU_PAIRS[row] : 8'($urandom());
            for (int op = 0; op < 8; op++) begin
                @(posedge clk);
                alu_op <= input_pkg::alu_op_e'(3'(op));
                alu_a  <= pair[7:4];
                alu_b  <= pair[3:0];
                @(posedge clk);
                expected = alu_expect(input_pkg::alu_op_e'(3'(op)), pair[7:4], pair[3:0]);
                checks += 4;
                if (alu_res !== expected[3:0]) begin
                    report_mismatch("alu_res", 32'(alu_res), 32'(expected[3:0]));
                end
                if (alu_zero !== expected[4]) begin
                    report_mismatch("alu_zero", 32'(alu_zero), 32'(expected[4]));
                end
                if (alu_carry !== expected[5]) begin
                    report_mismatch("alu_carry", 32'(alu_carry), 32'(expected[5]));
                end
                if (alu_overflow !== expected[6]) begin
                    report_mismatch("alu_overflow", 32'(alu_overflow), 32'(expected[6]));
                end
            end
        end

        for (int k = 0; k < 10; k++) begin
            key_row = KEY_TABLE[k];
            send_ps2_frame(key_row[7:0], key_row[8], got_valid);
            checks++;
            if (got_valid !== key_row[8]) begin
                report_mismatch("code_valid", 32'(got_valid), 32'(key_row[8]));
            end
            if (key_row[8]) begin
                shown[3] = shown[2];
                shown[2] = shown[1];
                shown[1] = shown[0];
                shown[0] = key_row[7:0];
                track_painter_key(key_row[7:0]);
            end
            @(negedge clk);
            check_display();
        end

        measure_sync(1'b0, period, low, found);
        if (!found) begin
            report_timeout("two horizontal sync pulses");
        end else begin
            checks += 2;
            if (period != `H_TOTAL) begin
                report_mismatch("hsync period", 32'(period), 32'(`H_TOTAL));
            end
            if (low != `H_SYNC_END - `H_SYNC_START) begin
                report_mismatch("hsync low", 32'(low), 32'(`H_SYNC_END - `H_SYNC_START));
            end
        end
        measure_sync(1'b1, period, low, found);
        if (!found) begin
            report_timeout("two vertical sync pulses");
        end else begin
            checks += 2;
            if (period != `V_TOTAL * `H_TOTAL) begin
                report_mismatch("vsync period", 32'(period), 32'(`V_TOTAL * `H_TOTAL));
            end
            if (low != (`V_SYNC_END - `V_SYNC_START) * `H_TOTAL) begin
                report_mismatch("vsync low", 32'(low),
                                32'((`V_SYNC_END - `V_SYNC_START) * `H_TOTAL));
            end
        end

        // Cursor cell, the cell painted twice, and a cell never painted.
        probe_cell(2, 1);
        probe_cell(0, 0);
        probe_cell(5, 3);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- lab_board.f
+incdir+logic
logic/video_pkg.sv
logic/input_pkg.sv
logic/ps2_receiver.sv
logic/alu_4bit.sv
logic/seg_display.sv
logic/vga_timing.sv
logic/cell_painter.sv
logic/vmem_arbiter.sv
logic/lab_board.sv
sim/clock_gen.sv
sim/lab_board_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module lab_board_tb -f lab_board.f -o lab_board_sim

output=$(./obj_dir/lab_board_sim)
echo "$output"

if echo "$output" | grep -qx "All checks passed"; then
    exit 0
else
    echo "simulation reported a failure"
    exit 1
fi
